//--- common/drac_pkg.sv
// ----------------------------------------------------------
// Register bus address map shared by the register bank, the
// health monitor and the top level. Import where needed.
// ----------------------------------------------------------
package drac_pkg;

    localparam int REG_ADDR_W = 16;
    localparam int REG_DATA_W = 32;

    // Region codes, upper address nibble
    localparam logic [3:0] REGION_MAIN  = 4'h0;
    localparam logic [3:0] REGION_BOARD = 4'hB;

    // Main region offsets, low nibble
    localparam logic [3:0] OFF_POT_DATA = 4'h0;
    localparam logic [3:0] OFF_ENC_LOAD = 4'h4;
    localparam logic [3:0] OFF_ENC_DATA = 4'h5;

    // Board-specific registers
    localparam logic [11:0] BRD_CRC_ERR  = 12'h000;
    localparam logic [11:0] BRD_CRC_GOOD = 12'h001;
    localparam logic [11:0] BRD_MV       = 12'h002;
    localparam logic [11:0] BRD_STATUS   = 12'h004;
    localparam logic [11:0] BRD_ESII     = 12'h010;
    localparam logic [11:0] BRD_INST_ID  = 12'h013;
    localparam logic [11:0] BRD_BUILD    = 12'hFFF;
    localparam logic [11:0] BRD_ESPMV_EN = 12'h102;

    localparam logic [REG_DATA_W-1:0] READ_DEFAULT = 32'h0000_CCCC;

    localparam logic [15:0] MV_NOMINAL   = 16'd36570; // 48 V
    localparam logic [15:0] MV_TOLERANCE = 16'd3657;  // About 4.8 V

    localparam int NUM_AXES = 7;

endpackage

//--- common/espm_pkg.sv
// ----------------------------------------------------------
// ESPM instrument frame layout. Word addresses, field widths
// and the union that decodes one position or pot word.
// ----------------------------------------------------------
package espm_pkg;

    localparam int ESPM_WORDS  = 64;
    localparam int ESPM_ADDR_W = 6;
    localparam int ENC_W       = 24;
    localparam int POT_W       = 12;

    localparam logic [ENC_W-1:0] ENC_MIDRANGE = 24'h80_0000;

    // Group field in word address bits 5:3, axis index in 2:0
    localparam logic [2:0] GRP_POS = 3'd1;
    localparam logic [2:0] GRP_POT = 3'd2;

    localparam logic [ESPM_ADDR_W-1:0] ESPM_ADDR_ESII    = 6'h00; // Bit 1 is ESII link good
    localparam logic [ESPM_ADDR_W-1:0] ESPM_ADDR_INST_ID = 6'h18;

    typedef union packed {
        struct packed {
            logic [7:0]       pad;
            logic [ENC_W-1:0] value;
        } pos;
        struct packed {
            logic [13:0]      pad_hi;
            logic [POT_W-1:0] value;
            logic [5:0]       pad_lo;
        } pot;
    } espm_word_u;

endpackage

//--- common/axis_if.sv
// ----------------------------------------------------------
// Link between the register bank and one encoder axis.
// Bank side writes the preload, axis side returns its state
// ----------------------------------------------------------
`timescale 1ns/1ps

interface axis_if;
    import espm_pkg::*;

    logic             preload_wen;
    logic [ENC_W-1:0] preload_data;
    logic [ENC_W-1:0] enc_data;     // Position plus offset
    logic [ENC_W-1:0] preload;
    logic [POT_W-1:0] pot;

    modport reg_bank (
        output preload_wen, preload_data,
        input  enc_data, preload, pot
    );

    modport axis (
        input  preload_wen, preload_data,
        output enc_data, preload, pot
    );
endinterface

//--- hw/espm/espm_rx_buffer.sv
// ----------------------------------------------------------
// Stages incoming ESPM frame words and counts good and bad
// frames. After a good frame, streams all 64 staged words
// out one per cycle so axes only see complete frames
// ----------------------------------------------------------
`timescale 1ns/1ps

module espm_rx_buffer (
    input  logic                             sysclk,
    input  logic                             arst_n,
    input  logic                             rx_load,
    input  logic [espm_pkg::ESPM_ADDR_W-1:0] rx_sel,
    input  logic [31:0]                      rx_data,
    input  logic                             rx_eof,
    input  logic                             rx_crc_good,
    output logic                             commit_valid,
    output logic [espm_pkg::ESPM_ADDR_W-1:0] commit_addr,
    output logic [31:0]                      commit_data,
    output logic [31:0]                      crc_good_count,
    output logic [31:0]                      crc_err_count,
    output logic                             frame_good
);
    import espm_pkg::*;

    logic [31:0]            stage_mem [ESPM_WORDS];
    logic                   wr_en;
    logic [ESPM_ADDR_W-1:0] wr_addr;
    logic [31:0]            wr_data;
    logic                   copy_busy;
    logic [ESPM_ADDR_W-1:0] rd_addr;

    // ------------------------------------------------------------
    // Staging and commit data path
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rx_load) begin
            wr_addr <= rx_sel;
            wr_data <= rx_data;
        end
        if (wr_en)
            stage_mem[wr_addr] <= wr_data;  // Lands one cycle after load
        commit_data <= stage_mem[rd_addr];
        commit_addr <= rd_addr;
    end

    // ------------------------------------------------------------
    // Copy FSM
    // ------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en        <= 1'b0;
            copy_busy    <= 1'b0;
            rd_addr      <= '0;
            commit_valid <= 1'b0;
        end else begin
            wr_en        <= rx_load;
            commit_valid <= copy_busy;
            if (copy_busy) begin
                rd_addr <= rd_addr + 1'b1;   // Wraps back to 0 after the last word
                if (rd_addr == ESPM_ADDR_W'(ESPM_WORDS - 1))
                    copy_busy <= 1'b0;
            end else if (rx_crc_good) begin
                copy_busy <= 1'b1;           // Good frame while busy is only counted
            end
        end
    end

    // Frame counters
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            crc_good_count <= '0;
            crc_err_count  <= '0;
            frame_good     <= 1'b0;
        end else begin
            frame_good <= rx_crc_good;
            if (rx_crc_good)
                crc_good_count <= crc_good_count + 1'b1;
            if (rx_eof && !rx_crc_good)
                crc_err_count <= crc_err_count + 1'b1;
        end
    end
endmodule

//--- hw/axis/encoder_axis.sv
// ----------------------------------------------------------
// One joint axis. Picks its position and pot words out of
// the commit stream and applies the host encoder preload
// ----------------------------------------------------------
`timescale 1ns/1ps

module encoder_axis #(
    parameter int AXIS_INDEX = 1
) (
    input  logic                             sysclk,
    input  logic                             arst_n,
    input  logic                             commit_valid,
    input  logic [espm_pkg::ESPM_ADDR_W-1:0] commit_addr,
    input  logic [31:0]                      commit_data,
    axis_if.axis                             link
);
    import espm_pkg::*;

    espm_word_u       word;
    logic             hit_pos;
    logic             hit_pot;
    logic [ENC_W-1:0] pos;
    logic [ENC_W-1:0] offset;
    logic [ENC_W-1:0] preload;
    logic [POT_W-1:0] pot;

    assign word    = commit_data;
    assign hit_pos = commit_valid && (commit_addr == {GRP_POS, 3'(AXIS_INDEX)});
    assign hit_pot = commit_valid && (commit_addr == {GRP_POT, 3'(AXIS_INDEX)});

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pos     <= '0;
            pot     <= '0;
            preload <= ENC_MIDRANGE;
            offset  <= ENC_MIDRANGE;
        end else begin
            if (hit_pos)
                pos <= word.pos.value;
            if (hit_pot)
                pot <= word.pot.value;
            if (link.preload_wen) begin
                preload <= link.preload_data;
                offset  <= link.preload_data - pos; // Modulo 2**24
            end
        end
    end

    assign link.enc_data = pos + offset;
    assign link.preload  = preload;
    assign link.pot      = pot;
endmodule

//--- hw/reg_bank.sv
// ----------------------------------------------------------
// Register bank. Decodes host writes to the axis preloads
// and ESPM supply enable, and muxes every readable register
// onto reg_rdata combinationally
// ----------------------------------------------------------
`timescale 1ns/1ps

module reg_bank (
    input  logic                             sysclk,
    input  logic                             arst_n,
    input  logic [drac_pkg::REG_ADDR_W-1:0]  reg_raddr,
    input  logic [drac_pkg::REG_ADDR_W-1:0]  reg_waddr,
    input  logic [drac_pkg::REG_DATA_W-1:0]  reg_wdata,
    input  logic                             reg_wen,
    input  logic                             commit_valid,
    input  logic [espm_pkg::ESPM_ADDR_W-1:0] commit_addr,
    input  logic [31:0]                      commit_data,
    input  logic [31:0]                      crc_good_count,
    input  logic [31:0]                      crc_err_count,
    input  logic [15:0]                      mv,
    input  logic                             mv_good,
    input  logic                             espm_comm_good,
    output logic [drac_pkg::REG_DATA_W-1:0]  reg_rdata,
    output logic                             espmv_en,
    axis_if.reg_bank                         axes [drac_pkg::NUM_AXES]
);
    import drac_pkg::*;
    import espm_pkg::*;

    logic             preload_wr;
    logic [3:0]       rd_axis;
    logic [2:0]       rd_idx;
    logic             axis_ok;
    logic [31:0]      esii_word;
    logic [31:0]      inst_id_word;
    logic [ENC_W-1:0] enc_data_a [NUM_AXES];
    logic [ENC_W-1:0] preload_a  [NUM_AXES];
    logic [POT_W-1:0] pot_a      [NUM_AXES];

    // ------------------------------------------------------------
    // Writes
    // ------------------------------------------------------------
    assign preload_wr = reg_wen && (reg_waddr[15:12] == REGION_MAIN)
                        && (reg_waddr[3:0] == OFF_ENC_LOAD);

    for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis
        assign axes[g].preload_wen  = preload_wr && (reg_waddr[7:4] == 4'(g + 1));
        assign axes[g].preload_data = reg_wdata[ENC_W-1:0];
        assign enc_data_a[g]        = axes[g].enc_data;
        assign preload_a[g]         = axes[g].preload;
        assign pot_a[g]             = axes[g].pot;
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n)
            espmv_en <= 1'b1;                // Supply on out of reset
        else if (reg_wen && reg_waddr[15:12] == REGION_BOARD
                 && reg_waddr[11:0] == BRD_ESPMV_EN)
            espmv_en <= reg_wdata[0];
    end

    // Misc frame words
    always_ff @(posedge sysclk) begin
        if (commit_valid && commit_addr == ESPM_ADDR_ESII)
            esii_word <= commit_data;
        if (commit_valid && commit_addr == ESPM_ADDR_INST_ID)
            inst_id_word <= commit_data;
    end

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    assign rd_axis = reg_raddr[7:4];
    assign rd_idx  = 3'(rd_axis - 4'd1);
    assign axis_ok = (rd_axis != 4'd0) && (rd_axis <= 4'(NUM_AXES));

    always_comb begin
        reg_rdata = READ_DEFAULT;
        case (reg_raddr[15:12])
            REGION_MAIN: begin
                if (axis_ok) begin
                    case (reg_raddr[3:0])
                        OFF_POT_DATA: reg_rdata = REG_DATA_W'(pot_a[rd_idx]);
                        OFF_ENC_LOAD: reg_rdata = REG_DATA_W'(preload_a[rd_idx]);
                        OFF_ENC_DATA: reg_rdata = REG_DATA_W'(enc_data_a[rd_idx]);
                        default:      reg_rdata = READ_DEFAULT;
                    endcase
                end
            end
            REGION_BOARD: begin
                case (reg_raddr[11:0])
                    BRD_CRC_ERR:  reg_rdata = crc_err_count;
                    BRD_CRC_GOOD: reg_rdata = crc_good_count;
                    BRD_MV:       reg_rdata = REG_DATA_W'(mv);
                    BRD_STATUS:   reg_rdata = REG_DATA_W'({espmv_en, mv_good, espm_comm_good});
                    BRD_ESII:     reg_rdata = esii_word;
                    BRD_INST_ID:  reg_rdata = inst_id_word;
                    BRD_BUILD:    reg_rdata = 32'd2;   // Build number
                    default:      reg_rdata = READ_DEFAULT;
                endcase
            end
            default: reg_rdata = READ_DEFAULT;
        endcase
    end
endmodule

//--- hw/health_monitor.sv
// ----------------------------------------------------------
// Motor supply window check and ESPM link watchdog. The
// watchdog drops when no good frame arrived in a tick period
// ----------------------------------------------------------
`timescale 1ns/1ps

module health_monitor #(
    parameter int WDT_PERIOD = 100_000
) (
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic        mv_valid,
    input  logic [15:0] mv_sample,
    input  logic        frame_good,
    output logic [15:0] mv,
    output logic        mv_good,
    output logic        espm_comm_good
);
    import drac_pkg::*;

    localparam int          TICK_W = $clog2(WDT_PERIOD);
    localparam logic [15:0] MV_LOW  = MV_NOMINAL - MV_TOLERANCE;
    localparam logic [15:0] MV_HIGH = MV_NOMINAL + MV_TOLERANCE;

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic [9:0]        good_cnt;
    logic [9:0]        good_prev;   // Good count seen at last tick

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            mv      <= '0;
            mv_good <= 1'b0;
        end else if (mv_valid) begin
            mv      <= mv_sample;
            mv_good <= (mv_sample > MV_LOW) && (mv_sample < MV_HIGH); // Strictly inside
        end
    end

    assign tick = (tick_cnt == TICK_W'(WDT_PERIOD - 1));

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt       <= '0;
            good_cnt       <= '0;
            good_prev      <= '0;
            espm_comm_good <= 1'b0;
        end else begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (frame_good)
                good_cnt <= good_cnt + 1'b1;
            if (tick) begin
                good_prev      <= good_cnt;
                espm_comm_good <= (good_cnt != good_prev);
            end
        end
    end
endmodule

//--- hw/drac_top.sv
// ----------------------------------------------------------
// Joint controller data path. Link frames in, register bus
// out. WDT_PERIOD sets the link watchdog tick in cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module drac_top #(
    parameter int WDT_PERIOD = 100_000
) (
    input  logic                              sysclk,
    input  logic                              arst_n,
    // ESPM link words
    input  logic                              rx_load,
    input  logic [espm_pkg::ESPM_ADDR_W-1:0]  rx_sel,
    input  logic [31:0]                       rx_data,
    input  logic                              rx_eof,
    input  logic                              rx_crc_good,
    // Motor supply samples
    input  logic                              mv_valid,
    input  logic [15:0]                       mv_sample,
    // Register bus
    input  logic [drac_pkg::REG_ADDR_W-1:0]   reg_raddr,
    input  logic [drac_pkg::REG_ADDR_W-1:0]   reg_waddr,
    input  logic [drac_pkg::REG_DATA_W-1:0]   reg_wdata,
    input  logic                              reg_wen,
    output logic [drac_pkg::REG_DATA_W-1:0]   reg_rdata,
    output logic                              espmv_en,
    output logic                              mv_good,
    output logic                              espm_comm_good
);
    import drac_pkg::*;
    import espm_pkg::*;

    logic                   commit_valid;
    logic [ESPM_ADDR_W-1:0] commit_addr;
    logic [31:0]            commit_data;
    logic [31:0]            crc_good_count;
    logic [31:0]            crc_err_count;
    logic                   frame_good;
    logic [15:0]            mv;

    axis_if axis_bus [NUM_AXES] ();

    espm_rx_buffer u_rx_buffer (
        .sysclk, .arst_n,
        .rx_load, .rx_sel, .rx_data, .rx_eof, .rx_crc_good,
        .commit_valid, .commit_addr, .commit_data,
        .crc_good_count, .crc_err_count, .frame_good
    );

    for (genvar g = 0; g < NUM_AXES; g++) begin : g_axis
        encoder_axis #(.AXIS_INDEX(g + 1)) u_axis ( // Axes numbered from 1
            .sysclk, .arst_n,
            .commit_valid, .commit_addr, .commit_data,
            .link(axis_bus[g])
        );
    end

    reg_bank u_reg_bank (
        .sysclk, .arst_n,
        .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen,
        .commit_valid, .commit_addr, .commit_data,
        .crc_good_count, .crc_err_count,
        .mv, .mv_good, .espm_comm_good,
        .reg_rdata, .espmv_en,
        .axes(axis_bus)
    );

    health_monitor #(.WDT_PERIOD(WDT_PERIOD)) u_health (
        .sysclk, .arst_n,
        .mv_valid, .mv_sample, .frame_good,
        .mv, .mv_good, .espm_comm_good
    );
endmodule

//--- bench/drac_checker.sv
// ----------------------------------------------------------
// Assertions on the voltage window and the link watchdog.
// Bound into every health_monitor instance
// ----------------------------------------------------------
`timescale 1ns/1ps

module drac_checker (
    input logic        sysclk,
    input logic        arst_n,
    input logic        mv_valid,
    input logic [15:0] mv_sample,
    input logic        mv_good,
    input logic        espm_comm_good,
    input logic        tick
);
    import drac_pkg::*;

    localparam logic [15:0] MV_LO = MV_NOMINAL - MV_TOLERANCE;
    localparam logic [15:0] MV_HI = MV_NOMINAL + MV_TOLERANCE;

    int err_count = 0;   // Failed assertions so far

    // Strictly inside the window, one cycle later
    a_mv_window: assert property (@(posedge sysclk) disable iff (!arst_n)
        mv_valid |=> (mv_good == (($past(mv_sample) > MV_LO) && ($past(mv_sample) < MV_HI))))
        else begin
            $error("mv_good does not follow the voltage window of the last sample");
            err_count = err_count + 1;
        end

    a_comm_at_tick: assert property (@(posedge sysclk) disable iff (!arst_n)
        !tick |=> $stable(espm_comm_good))
        else begin
            $error("espm_comm_good changed away from a watchdog tick");
            err_count = err_count + 1;
        end

    a_mv_reset: assert property (@(posedge sysclk) $rose(arst_n) |-> !mv_good)
        else begin
            $error("mv_good is high right after reset");
            err_count = err_count + 1;
        end
endmodule

bind health_monitor drac_checker u_checker (
    .sysclk(sysclk), .arst_n(arst_n),
    .mv_valid(mv_valid), .mv_sample(mv_sample),
    .mv_good(mv_good), .espm_comm_good(espm_comm_good),
    .tick(tick)
);

//--- bench/drac_tb.sv
// ----------------------------------------------------------
// Testbench for the joint controller data path. Builds a
// table of link frames, bus writes, voltage samples and
// expected reads, then applies it to the DUT in one loop
// ----------------------------------------------------------
`timescale 1ns/1ps

module drac_tb;
    import drac_pkg::*;
    import espm_pkg::*;

    localparam logic [31:0] SEED        = 32'h921c_2758;
    localparam int          COMMIT_WAIT = 67;   // Commit settles within 67 cycles
    localparam int          MAX_FRAMES  = 8;

    typedef enum logic [2:0] {K_FRAME, K_WRITE, K_MV, K_WAIT, K_READ, K_PIN} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [15:0] addr;   // Register address, pin select or CRC flag
        logic [31:0] data;   // Write data, expected value, count or frame number
    } step_t;

    logic                   sysclk;
    logic                   arst_n;
    logic                   rx_load;
    logic [ESPM_ADDR_W-1:0] rx_sel;
    logic [31:0]            rx_data;
    logic                   rx_eof;
    logic                   rx_crc_good;
    logic                   mv_valid;
    logic [15:0]            mv_sample;
    logic [REG_ADDR_W-1:0]  reg_raddr;
    logic [REG_ADDR_W-1:0]  reg_waddr;
    logic [REG_DATA_W-1:0]  reg_wdata;
    logic                   reg_wen;
    logic [REG_DATA_W-1:0]  reg_rdata;
    logic                   espmv_en;
    logic                   mv_good;
    logic                   espm_comm_good;

    step_t       steps [$];
    logic [31:0] frame_words [MAX_FRAMES][ESPM_WORDS];
    int          n_frames;
    int          cycle_count = 0;
    int          cycle_limit = 1_000_000;

    // Reference state built from the register map rules
    logic [ENC_W-1:0] pos_m [NUM_AXES];
    logic [ENC_W-1:0] off_m [NUM_AXES];
    logic [ENC_W-1:0] pre_m [NUM_AXES];
    logic [POT_W-1:0] pot_m [NUM_AXES];
    logic [31:0]      esii_m;
    logic [31:0]      inst_m;
    logic [31:0]      good_m;
    logic [31:0]      err_m;
    logic             espmv_m;
    logic             mv_good_m;

    drac_top #(.WDT_PERIOD(256)) UUT (
        .sysclk(sysclk), .arst_n(arst_n),
        .rx_load(rx_load), .rx_sel(rx_sel), .rx_data(rx_data),
        .rx_eof(rx_eof), .rx_crc_good(rx_crc_good),
        .mv_valid(mv_valid), .mv_sample(mv_sample),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen),
        .reg_rdata(reg_rdata), .espmv_en(espmv_en),
        .mv_good(mv_good), .espm_comm_good(espm_comm_good)
    );

    always #10 sysclk = ~sysclk;

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the test table did not finish", cycle_limit);
            fail_run();
        end
    end

    // ------------------------------------------------------------
    // Compare helpers
    // ------------------------------------------------------------
    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(string name, logic [REG_DATA_W-1:0] got,
                              logic [REG_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge sysclk);
        #2;                  // Drive just after the edge
    endtask

    // ------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------
    function automatic logic [15:0] main_addr(int axis, logic [3:0] off);
        return {REGION_MAIN, 4'h0, 4'(axis), off};
    endfunction

    function automatic logic [15:0] board_addr(logic [11:0] reg_sel);
        return {REGION_BOARD, reg_sel};
    endfunction

    task automatic add_step(kind_e kind, logic [15:0] addr, logic [31:0] data);
        step_t s;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic expect_axes();
        logic [ENC_W-1:0] enc;
        for (int a = 1; a <= NUM_AXES; a++) begin
            enc = pos_m[a-1] + off_m[a-1];   // Wraps at 24 bits
            add_step(K_READ, main_addr(a, OFF_POT_DATA), 32'(pot_m[a-1]));
            add_step(K_READ, main_addr(a, OFF_ENC_LOAD), 32'(pre_m[a-1]));
            add_step(K_READ, main_addr(a, OFF_ENC_DATA), 32'(enc));
        end
    endtask

    task automatic make_frame(logic good);
        for (int i = 0; i < ESPM_WORDS; i++)
            frame_words[n_frames][i] = $urandom();
        add_step(K_FRAME, 16'(good), 32'(n_frames));
        if (good) begin
            for (int a = 1; a <= NUM_AXES; a++) begin
                pos_m[a-1] = frame_words[n_frames][8 + a][23:0];   // Group 1
                pot_m[a-1] = frame_words[n_frames][16 + a][17:6];  // Group 2
            end
            esii_m = frame_words[n_frames][0];
            inst_m = frame_words[n_frames][24];
            good_m = good_m + 1;
        end else begin
            err_m = err_m + 1;
        end
        n_frames++;
        add_step(K_WAIT, 16'h0, 32'(COMMIT_WAIT));
    endtask

    task automatic write_preload(int axis, logic [ENC_W-1:0] value);
        add_step(K_WRITE, main_addr(axis, OFF_ENC_LOAD), 32'(value));
        pre_m[axis-1] = value;
        off_m[axis-1] = value - pos_m[axis-1];
    endtask

    task automatic send_sample(int value);
        int lo;
        int hi;
        lo = int'(MV_NOMINAL) - int'(MV_TOLERANCE);
        hi = int'(MV_NOMINAL) + int'(MV_TOLERANCE);
        mv_good_m = (value > lo) && (value < hi);
        add_step(K_MV, 16'h0, 32'(value));
        add_step(K_PIN, 16'd1, 32'(mv_good_m));
        add_step(K_READ, board_addr(BRD_STATUS), 32'({espmv_m, mv_good_m, 1'b0}));
        add_step(K_READ, board_addr(BRD_MV), 32'(value));
    endtask

    task automatic build_table();
        int samples [3];
        samples[0] = int'(MV_NOMINAL);
        samples[1] = int'(MV_NOMINAL) + int'(MV_TOLERANCE);
        samples[2] = 30000;
        n_frames  = 0;
        good_m    = '0;
        err_m     = '0;
        espmv_m   = 1'b1;
        mv_good_m = 1'b0;
        for (int a = 0; a < NUM_AXES; a++) begin
            pos_m[a] = '0;
            pot_m[a] = '0;
            pre_m[a] = ENC_MIDRANGE;
            off_m[a] = ENC_MIDRANGE;
        end

        // Reset state and unmapped addresses
        add_step(K_PIN, 16'd0, 32'd1);
        add_step(K_PIN, 16'd1, 32'd0);
        add_step(K_PIN, 16'd2, 32'd0);
        expect_axes();
        add_step(K_READ, main_addr(0, OFF_ENC_LOAD), READ_DEFAULT);
        add_step(K_READ, main_addr(1, 4'h3), READ_DEFAULT);
        add_step(K_READ, main_addr(8, OFF_POT_DATA), READ_DEFAULT);
        add_step(K_READ, board_addr(12'h005), READ_DEFAULT);
        add_step(K_READ, 16'h5000, READ_DEFAULT);
        add_step(K_READ, board_addr(BRD_BUILD), 32'd2);
        add_step(K_READ, board_addr(BRD_CRC_GOOD), 32'd0);
        add_step(K_READ, board_addr(BRD_CRC_ERR), 32'd0);

        // Voltage window and supply enable, no frames yet so link status is 0
        foreach (samples[i])
            send_sample(samples[i]);
        add_step(K_WRITE, board_addr(BRD_ESPMV_EN), 32'd0);
        espmv_m = 1'b0;
        add_step(K_PIN, 16'd0, 32'd0);
        add_step(K_READ, board_addr(BRD_STATUS), 32'({espmv_m, mv_good_m, 1'b0}));

        // Good frame
        make_frame(1'b1);
        expect_axes();
        add_step(K_READ, board_addr(BRD_ESII), esii_m);
        add_step(K_READ, board_addr(BRD_INST_ID), inst_m);
        add_step(K_READ, board_addr(BRD_CRC_GOOD), good_m);

        // Bad frame leaves committed values alone
        make_frame(1'b0);
        add_step(K_READ, board_addr(BRD_CRC_ERR), err_m);
        expect_axes();

        // Preload then a fresh frame
        write_preload(3, ENC_W'($urandom()));
        expect_axes();
        make_frame(1'b1);
        expect_axes();
        add_step(K_READ, board_addr(BRD_CRC_GOOD), good_m);

        // Watchdog, frames every ~132 cycles then a long silence
        repeat (4) make_frame(1'b1);
        add_step(K_PIN, 16'd2, 32'd1);
        add_step(K_READ, board_addr(BRD_STATUS), 32'({espmv_m, mv_good_m, 1'b1}));
        add_step(K_WAIT, 16'h0, 32'd600);
        add_step(K_PIN, 16'd2, 32'd0);
        add_step(K_READ, board_addr(BRD_STATUS), 32'({espmv_m, mv_good_m, 1'b0}));
    endtask

    // ------------------------------------------------------------
    // Table application
    // ------------------------------------------------------------
    task automatic send_frame(int idx, logic good);
        for (int i = 0; i < ESPM_WORDS; i++) begin
            rx_load = 1'b1;
            rx_sel  = ESPM_ADDR_W'(i);
            rx_data = frame_words[idx][i];
            next_cycle();
        end
        rx_load     = 1'b0;
        rx_eof      = 1'b1;
        rx_crc_good = good;
        next_cycle();
        rx_eof      = 1'b0;
        rx_crc_good = 1'b0;
    endtask

    task automatic apply_step(step_t s);
        case (s.kind)
            K_FRAME: send_frame(int'(s.data), s.addr[0]);
            K_WRITE: begin
                reg_waddr = s.addr;
                reg_wdata = s.data;
                reg_wen   = 1'b1;
                next_cycle();
                reg_wen   = 1'b0;
            end
            K_MV: begin
                mv_sample = s.data[15:0];
                mv_valid  = 1'b1;
                next_cycle();
                mv_valid  = 1'b0;
            end
            K_WAIT: repeat (s.data) next_cycle();
            K_READ: begin
                reg_raddr = s.addr;
                @(negedge sysclk);               // Mid-cycle, rdata settled
                check_word($sformatf("reg_rdata @0x%h", s.addr), reg_rdata, s.data);
                next_cycle();
            end
            K_PIN: begin
                @(negedge sysclk);
                case (s.addr)
                    16'd0:   check_bit("espmv_en", espmv_en, s.data[0]);
                    16'd1:   check_bit("mv_good", mv_good, s.data[0]);
                    default: check_bit("espm_comm_good", espm_comm_good, s.data[0]);
                endcase
                next_cycle();
            end
            default: begin
                $display("Unknown step kind in the test table");
                fail_run();
            end
        endcase
    endtask

    initial begin
        int total;
        void'($urandom(SEED));
        sysclk      = 1'b0;
        arst_n      = 1'b0;
        rx_load     = 1'b0;
        rx_sel      = '0;
        rx_data     = '0;
        rx_eof      = 1'b0;
        rx_crc_good = 1'b0;
        mv_valid    = 1'b0;
        mv_sample   = '0;
        reg_raddr   = '0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_wen     = 1'b0;

        build_table();
        total = 10;
        foreach (steps[i]) begin
            case (steps[i].kind)
                K_FRAME: total += ESPM_WORDS + 1;
                K_WAIT:  total += int'(steps[i].data);
                default: total += 1;
            endcase
        end
        cycle_limit = 2 * total + 100;   // Generous margin over table length

        repeat (5) @(posedge sysclk);
        #2 arst_n = 1'b1;
        foreach (steps[i])
            apply_step(steps[i]);

        if (UUT.u_health.u_checker.err_count != 0) begin
            $display("Health monitor assertions failed %0d times",
                     UUT.u_health.u_checker.err_count);
            fail_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end
endmodule

//--- files.f
common/drac_pkg.sv
common/espm_pkg.sv
common/axis_if.sv
hw/espm/espm_rx_buffer.sv
hw/axis/encoder_axis.sv
hw/reg_bank.sv
hw/health_monitor.sv
hw/drac_top.sv
bench/drac_checker.sv
bench/drac_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the joint controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module drac_tb -f files.f -o drac_sim

./obj_dir/drac_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log || ! grep -q "Everything OK" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"
